// File: vlog.f
sc32_pkg.sv
sc32_alu.sv
sc32_regfile.sv
sc32_imm_gen.sv
sc32_control.sv
sc32_datapath.sv
sc32_core.sv
sc32_core_checker.sv
tb_sc32_core.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_sc32_core
FILELIST  ?= vlog.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_sc32_core.sv
`timescale 1ns/1ps

module tb_sc32_core;
    import sc32_pkg::*;

    localparam word_t NOP = 32'h0000_0013; // addi x0,x0,0

    typedef struct packed {
        word_t     instr;
        word_t     pc;
        word_t     pc_next;
        logic      wb_en;
        reg_addr_t rd;
        word_t     wb_data;
        logic      we;
        word_t     addr;
        word_t     wdata;
        logic      alu_en;
        word_t     alu;
    } row_t;

    logic      clk;
    logic      rst;
    word_t     imem_data;
    word_t     dmem_rdata;
    word_t     imem_addr, dmem_addr, dmem_wdata, pc, pc_next, alu_result, wb_data;
    logic      dmem_we, wb_en;
    reg_addr_t wb_rd;

    word_t     mem [64];
    word_t     smem [64];  // expected memory contents
    word_t     shadow [32]; // expected register contents
    row_t      rows [$];
    word_t     pc_model;
    logic [31:0] lfsr_state;
    int        limit_ns;

    sc32_core #(.P_IMEM_WORDS(64)) i_dut (
        .clk (clk), .rst (rst), .i_imem_data (imem_data), .i_dmem_rdata (dmem_rdata),
        .o_imem_addr (imem_addr), .o_dmem_addr (dmem_addr), .o_dmem_wdata (dmem_wdata),
        .o_dmem_we (dmem_we), .o_pc (pc), .o_pc_next (pc_next),
        .o_alu_result (alu_result), .o_wb_en (wb_en), .o_wb_rd (wb_rd),
        .o_wb_data (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign dmem_rdata = mem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) mem[dmem_addr[7:2]] <= dmem_wdata;
    end

    function automatic word_t fill_word(input int i);
        return (word_t'(i) * 32'h0103_0507) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t rv(input reg_addr_t r);
        return (r == '0) ? '0 : shadow[r];
    endfunction

    // expected alu result from funct3 and the alternate bit
    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
            fail_run($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic put(input word_t instr, input logic en, input reg_addr_t rd,
                       input word_t data, input logic we, input word_t addr,
                       input word_t wdata, input word_t nxt, input logic alu_en,
                       input word_t alu);
        row_t r;
        r = '{instr, pc_model, nxt & 32'hfc, en, rd, data, we, addr, wdata, alu_en, alu};
        rows.push_back(r);
        if (en && rd != '0) shadow[rd] = data;
        if (we) smem[addr[7:2]] = wdata;
        pc_model = r.pc_next;
    endtask

    task automatic op_r(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                        input reg_addr_t rs1, input reg_addr_t rs2);
        word_t res;
        res = ref_alu(f3, alt, rv(rs1), rv(rs2));
        put({1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP}, 1'b1, rd, res, 1'b0, '0, '0,
            pc_model + 4, 1'b1, res);
    endtask

    task automatic op_i(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                        input reg_addr_t rs1, input logic [11:0] imm);
        logic [11:0] f;
        word_t res;
        // shifts take the amount from imm[4:0], imm[10] selects sra
        if (f3 == 3'd1 || f3 == 3'd5) begin
            f = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]};
        end else begin
            f = imm;
        end
        res = ref_alu(f3, f3 == 3'd5 && f[10], rv(rs1), sext12(f));
        put({f, rs1, f3, rd, OPC_OP_IMM}, 1'b1, rd, res, 1'b0, '0, '0,
            pc_model + 4, 1'b1, res);
    endtask

    task automatic lui(input reg_addr_t rd, input logic [19:0] imm);
        put({imm, rd, OPC_LUI}, 1'b1, rd, {imm, 12'b0}, 1'b0, '0, '0, pc_model + 4,
            1'b1, {imm, 12'b0});
    endtask

    task automatic auipc(input reg_addr_t rd, input logic [19:0] imm);
        put({imm, rd, OPC_AUIPC}, 1'b1, rd, pc_model + {imm, 12'b0}, 1'b0, '0, '0,
            pc_model + 4, 1'b1, pc_model + {imm, 12'b0});
    endtask

    task automatic sw(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] imm);
        word_t addr;
        addr = rv(rs1) + sext12(imm);
        put({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE}, 1'b0, '0, '0, 1'b1,
            addr, rv(rs2), pc_model + 4, 1'b1, addr);
    endtask

    task automatic load(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                        input logic [11:0] imm);
        word_t addr, w, v;
        logic [7:0] b;
        logic [15:0] h;
        addr = rv(rs1) + sext12(imm);
        w = smem[addr[7:2]];
        b = w[8 * (3 - int'(addr[1:0])) +: 8]; // offset 0 is the top byte
        h = addr[1] ? w[15:0] : w[31:16];
        case (f3)
            3'd0:    v = {{24{b[7]}}, b};
            3'd1:    v = {{16{h[15]}}, h};
            3'd4:    v = {24'b0, b};
            3'd5:    v = {16'b0, h};
            default: v = w;
        endcase
        put({imm, rs1, f3, rd, OPC_LOAD}, 1'b1, rd, v, 1'b0, '0, '0, pc_model + 4,
            1'b1, addr);
    endtask

    task automatic br(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2,
                      input logic [12:0] off);
        logic taken;
        word_t a, b, res;
        a = rv(rs1);
        b = rv(rs2);
        case (f3)
            3'd0:    taken = rv(rs1) == rv(rs2);
            3'd1:    taken = rv(rs1) != rv(rs2);
            3'd4:    taken = $signed(rv(rs1)) < $signed(rv(rs2));
            3'd5:    taken = $signed(rv(rs1)) >= $signed(rv(rs2));
            3'd6:    taken = rv(rs1) < rv(rs2);
            default: taken = rv(rs1) >= rv(rs2);
        endcase
        // sub for beq and bne, slt for blt and bge, sltu for bltu and bgeu
        if (!f3[2]) begin
            res = a - b;
        end else if (f3[1]) begin
            res = (a < b) ? 32'd1 : 32'd0;
        end else begin
            res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        end
        put({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH}, 1'b0, '0,
            '0, 1'b0, '0, '0, taken ? pc_model + {{19{off[12]}}, off} : pc_model + 4,
            1'b1, res);
    endtask

    task automatic jal(input reg_addr_t rd, input logic [20:0] off);
        put({off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL}, 1'b1, rd, pc_model + 4,
            1'b0, '0, '0, pc_model + {{11{off[20]}}, off}, 1'b0, '0);
    endtask

    task automatic jalr(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        put({imm, rs1, 3'b000, rd, OPC_JALR}, 1'b1, rd, pc_model + 4, 1'b0, '0, '0,
            (rv(rs1) + sext12(imm)) & ~32'd1, 1'b1, rv(rs1) + sext12(imm));
    endtask

    task automatic check_row(input row_t r);
        check_word("o_pc", pc, r.pc);
        check_word("o_imem_addr", imem_addr, r.pc);
        check_word("o_pc_next", pc_next, r.pc_next);
        check_bit("o_wb_en", wb_en, r.wb_en);
        check_bit("o_dmem_we", dmem_we, r.we);
        if (r.wb_en) begin
            check_reg("o_wb_rd", wb_rd, r.rd);
            check_word("o_wb_data", wb_data, r.wb_data);
        end
        if (r.we) begin
            check_word("o_dmem_addr", dmem_addr, r.addr);
            check_word("o_dmem_wdata", dmem_wdata, r.wdata);
        end
        if (r.alu_en) begin
            check_word("o_alu_result", alu_result, r.alu);
        end
    endtask

    task automatic build_rows();
        word_t a;
        logic [2:0] f3;
        op_r(3'd0, 1'b0, 5, 6, 7);  // regs read zero after reset
        op_r(3'd6, 1'b0, 8, 31, 30);
        op_i(3'd0, 1'b0, 1, 0, 12'h123);
        op_i(3'd0, 1'b0, 2, 0, 12'hf85);
        lui(3, 20'h80000);
        for (int f = 0; f < 8; f++) op_r(3'(f), 1'b0, 5'(10 + f), 1, 2);
        op_r(3'd0, 1'b1, 18, 1, 2); // sub
        op_r(3'd5, 1'b1, 19, 3, 1); // sra of a negative value
        for (int f = 1; f < 8; f++) op_i(3'(f), 1'b0, 5'(10 + f), 2, 12'hf07);
        op_i(3'd5, 1'b1, 18, 3, 12'h00c); // srai
        auipc(12, 20'h00012);
        op_i(3'd0, 1'b0, 0, 1, 12'h7ff); // write to x0
        op_r(3'd0, 1'b0, 13, 0, 0);
        op_i(3'd0, 1'b0, 20, 0, 12'h040);
        lui(21, 20'h8172f);
        op_i(3'd0, 1'b0, 21, 21, 12'h3e4);
        sw(21, 20, 12'h000);
        sw(2, 20, 12'h004);
        load(3'd2, 22, 20, 12'h000);
        load(3'd2, 22, 20, 12'h004);
        for (int o = 0; o < 4; o++) begin
            load(3'd0, 23, 20, 12'(o));
            load(3'd4, 24, 20, 12'(o));
        end
        for (int o = 0; o < 4; o += 2) begin
            load(3'd1, 25, 20, 12'(o));
            load(3'd5, 26, 20, 12'(o));
        end
        br(3'd0, 1, 1, 13'd8);
        br(3'd0, 1, 2, 13'd8);
        br(3'd1, 1, 2, 13'd16);
        br(3'd1, 1, 1, 13'd8);
        br(3'd4, 2, 1, 13'h1ff8); // backward
        br(3'd4, 1, 2, 13'd8);
        br(3'd5, 1, 2, 13'd8);
        br(3'd5, 2, 1, 13'd8);
        br(3'd6, 1, 2, 13'd12);
        br(3'd6, 2, 1, 13'd8);
        br(3'd7, 2, 1, 13'd8);
        br(3'd7, 1, 2, 13'd8);
        jal(1, 21'd12);
        jalr(5, 20, 12'h00c);
        jalr(6, 0, 12'h021); // bit 0 cleared
        for (int k = 0; k < 8; k++) begin
            for (int r = 1; r <= 2; r++) begin
                a = rand_bits(32);
                lui(5'(r), 20'((a + 32'h800) >> 12));
                op_i(3'd0, 1'b0, 5'(r), 5'(r), a[11:0]);
            end
            for (int j = 0; j < 4; j++) begin
                f3 = 3'(rand_bits(3));
                op_r(f3, rand_bits(1) == 1 && (f3 == 3'd0 || f3 == 3'd5), 5'(3 + j), 1, 2);
            end
        end
    endtask

    initial begin
        limit_ns = 0;
        wait (limit_ns > 0);
        #(limit_ns);
        fail_run("timeout: the run did not finish in the expected time");
    end

    initial begin
        rst = 1'b1;
        imem_data = NOP;
        lfsr_state = 32'h9b3a_d364;
        pc_model = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] <= fill_word(i);
            smem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        build_rows();
        limit_ns = (rows.size() + 8 + 20) * 4;
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_word("o_pc", pc, '0);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            if (i == 0) rst <= 1'b0;
            imem_data <= rows[i].instr;
            @(negedge clk);
            check_row(rows[i]);
        end
        @(posedge clk);
        imem_data <= NOP;
        @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: sc32_core_checker.sv
`timescale 1ns/1ps

module sc32_core_checker (
    input logic                clk,
    input logic                rst,
    input sc32_pkg::word_t     i_next_pc,
    input logic                i_dmem_we,
    input logic                i_wb_en,
    input sc32_pkg::reg_addr_t i_wb_rd,
    input sc32_pkg::word_t     i_x0_value
);
    // branch and jump targets land on word boundaries
    a_target_aligned: assert property (@(posedge clk) disable iff (rst)
        i_next_pc[1:0] == 2'b00)
        else $error("next pc target not word aligned");

    a_store_no_wb: assert property (@(posedge clk) disable iff (rst)
        !(i_dmem_we && i_wb_en))
        else $error("store together with register write");

    // x0 stays zero after being targeted
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (i_wb_en && i_wb_rd == '0) |=> i_x0_value == '0)
        else $error("x0 changed after write");

endmodule

bind sc32_core sc32_core_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .i_next_pc   (u_datapath.next_pc),
    .i_dmem_we   (o_dmem_we),
    .i_wb_en     (o_wb_en),
    .i_wb_rd     (o_wb_rd),
    .i_x0_value  (u_datapath.u_regfile.regs[0])
);

// File: sc32_core.sv
`timescale 1ns/1ps

module sc32_core #(
    parameter int P_IMEM_WORDS = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  sc32_pkg::word_t     i_imem_data,
    input  sc32_pkg::word_t     i_dmem_rdata,
    output sc32_pkg::word_t     o_imem_addr,
    output sc32_pkg::word_t     o_dmem_addr,
    output sc32_pkg::word_t     o_dmem_wdata,
    output logic                o_dmem_we,
    output sc32_pkg::word_t     o_pc,
    output sc32_pkg::word_t     o_pc_next,
    output sc32_pkg::word_t     o_alu_result,
    output logic                o_wb_en,
    output sc32_pkg::reg_addr_t o_wb_rd,
    output sc32_pkg::word_t     o_wb_data
);
    import sc32_pkg::*;

    ctrl_t ctrl;
    word_t instr;

    sc32_datapath #(
        .P_IMEM_WORDS (P_IMEM_WORDS)
    ) u_datapath (
        .clk          (clk),
        .rst          (rst),
        .i_ctrl       (ctrl),
        .i_imem_data  (i_imem_data),
        .i_dmem_rdata (i_dmem_rdata),
        .o_instr      (instr),
        .o_imem_addr  (o_imem_addr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we),
        .o_alu_result (o_alu_result),
        .o_pc_next    (o_pc_next),
        .o_wb_data    (o_wb_data)
    );

    sc32_control u_control (
        .i_instr (instr),
        .o_ctrl  (ctrl)
    );

    // trace
    assign o_pc    = o_imem_addr;
    assign o_wb_en = ctrl.reg_write;
    assign o_wb_rd = instr[11:7];

endmodule

// File: sc32_datapath.sv
`timescale 1ns/1ps

module sc32_datapath #(
    parameter int P_IMEM_WORDS = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  sc32_pkg::ctrl_t i_ctrl,
    input  sc32_pkg::word_t i_imem_data,
    input  sc32_pkg::word_t i_dmem_rdata,
    output sc32_pkg::word_t o_instr,
    output sc32_pkg::word_t o_imem_addr,
    output sc32_pkg::word_t o_dmem_addr,
    output sc32_pkg::word_t o_dmem_wdata,
    output logic            o_dmem_we,
    output sc32_pkg::word_t o_alu_result,
    output sc32_pkg::word_t o_pc_next,
    output sc32_pkg::word_t o_wb_data
);
    import sc32_pkg::*;

    localparam int PC_W = $clog2(P_IMEM_WORDS) + 2;

    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_d;
    word_t           pc_word;
    word_t           pc_plus4;
    word_t           pc_target; // branch and jal target
    word_t           next_pc;
    reg_addr_t       rs1_addr;
    word_t           rdata1;
    word_t           rdata2;
    word_t           imm;
    word_t           alu_a;
    word_t           alu_b;
    word_t           alu_result;
    logic            alu_zero;
    logic            take_branch;
    logic [7:0]      load_byte;
    logic [15:0]     load_half;
    word_t           load_data;
    word_t           wb_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_word   = word_t'(pc_q);
    assign pc_plus4  = pc_word + 32'd4;
    assign pc_target = pc_word + imm;

    // lui adds its immediate to x0, rs1 field is part of the immediate
    assign rs1_addr = (i_imem_data[6:0] == OPC_LUI) ? '0 : i_imem_data[19:15];

    sc32_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .i_rs1    (rs1_addr),
        .i_rs2    (i_imem_data[24:20]),
        .i_rd     (i_imem_data[11:7]),
        .i_we     (i_ctrl.reg_write),
        .i_wdata  (wb_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    sc32_imm_gen u_imm_gen (
        .i_instr (i_imem_data),
        .o_imm   (imm)
    );

    assign alu_a = i_ctrl.alu_a_pc ? pc_word : rdata1;
    assign alu_b = i_ctrl.alu_src_imm ? imm : rdata2;

    sc32_alu u_alu (
        .i_op     (i_ctrl.alu_op),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    // big-endian lanes, offset 0 is bits 31:24
    always_comb begin
        case (alu_result[1:0])
            2'd0:    load_byte = i_dmem_rdata[31:24];
            2'd1:    load_byte = i_dmem_rdata[23:16];
            2'd2:    load_byte = i_dmem_rdata[15:8];
            default: load_byte = i_dmem_rdata[7:0];
        endcase
        load_half = alu_result[1] ? i_dmem_rdata[15:0] : i_dmem_rdata[31:16];
        case (i_imem_data[14:12])
            3'b000:  load_data = {{24{load_byte[7]}}, load_byte};  // lb
            3'b001:  load_data = {{16{load_half[15]}}, load_half}; // lh
            3'b100:  load_data = {24'b0, load_byte};               // lbu
            3'b101:  load_data = {16'b0, load_half};               // lhu
            default: load_data = i_dmem_rdata;                     // lw
        endcase
    end

    always_comb begin
        case (i_ctrl.wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    assign take_branch = i_ctrl.branch &&
                         (i_ctrl.branch_on_nonzero ? !alu_zero : alu_zero);

    always_comb begin
        case (i_ctrl.pc_sel)
            PC_JAL:  next_pc = pc_target;
            PC_JALR: next_pc = alu_result & ~32'd1;
            default: next_pc = take_branch ? pc_target : pc_plus4;
        endcase
    end

    assign pc_d = {next_pc[PC_W-1:2], 2'b00}; // keep word aligned

    assign o_instr      = i_imem_data;
    assign o_imem_addr  = pc_word;
    assign o_dmem_addr  = alu_result;
    assign o_dmem_wdata = rdata2;
    assign o_dmem_we    = i_ctrl.mem_write;
    assign o_alu_result = alu_result;
    assign o_pc_next    = word_t'(pc_d);
    assign o_wb_data    = wb_data;

endmodule

// File: sc32_control.sv
`timescale 1ns/1ps

module sc32_control (
    input  sc32_pkg::word_t i_instr,
    output sc32_pkg::ctrl_t o_ctrl
);
    import sc32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;
    alu_op_t    arith_op;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign bit30  = i_instr[30];

    // op / op-imm operation from funct3
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && bit30) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = bit30 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        o_ctrl = '0;
        o_ctrl.alu_op = ALU_ADD;
        o_ctrl.pc_sel = PC_SEQ;
        o_ctrl.wb_sel = WB_ALU;
        case (opcode)
            OPC_LUI: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1; // x0 + imm
            end
            OPC_AUIPC: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.alu_a_pc    = 1'b1;
            end
            OPC_JAL: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.pc_sel    = PC_JAL;
                o_ctrl.wb_sel    = WB_PC4;
            end
            OPC_JALR: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.pc_sel      = PC_JALR;
                o_ctrl.wb_sel      = WB_PC4;
            end
            OPC_BRANCH: begin
                o_ctrl.branch            = 1'b1;
                o_ctrl.branch_on_nonzero = funct3[2] ^ funct3[0]; // bne, blt, bltu
                if (!funct3[2]) begin
                    o_ctrl.alu_op = ALU_SUB;
                end else begin
                    o_ctrl.alu_op = funct3[1] ? ALU_SLTU : ALU_SLT;
                end
            end
            OPC_LOAD: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.wb_sel      = WB_MEM;
            end
            OPC_STORE: begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.mem_write   = 1'b1;
            end
            OPC_OP_IMM: begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.alu_op      = arith_op;
            end
            OPC_OP: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = arith_op;
            end
            default: o_ctrl = '0;
        endcase
    end

endmodule

// File: sc32_imm_gen.sv
`timescale 1ns/1ps

module sc32_imm_gen (
    input  sc32_pkg::word_t i_instr,
    output sc32_pkg::word_t o_imm
);
    import sc32_pkg::*;

    logic [6:0] opcode;

    assign opcode = i_instr[6:0];

    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_OP_IMM, OPC_JALR: // i-type
                o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            OPC_STORE:
                o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            OPC_BRANCH:
                o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                         i_instr[30:25], i_instr[11:8], 1'b0};
            OPC_JAL:
                o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                         i_instr[20], i_instr[30:21], 1'b0};
            OPC_LUI, OPC_AUIPC:
                o_imm = {i_instr[31:12], 12'b0};
            default:
                o_imm = '0; // r-type and unknown
        endcase
    end

endmodule

// File: sc32_regfile.sv
`timescale 1ns/1ps

module sc32_regfile (
    input  logic                clk,
    input  logic                rst,
    input  sc32_pkg::reg_addr_t i_rs1,
    input  sc32_pkg::reg_addr_t i_rs2,
    input  sc32_pkg::reg_addr_t i_rd,
    input  logic                i_we,
    input  sc32_pkg::word_t     i_wdata,
    output sc32_pkg::word_t     o_rdata1,
    output sc32_pkg::word_t     o_rdata2
);
    import sc32_pkg::*;

    word_t regs [32];

    // x0 reads as zero
    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

// File: sc32_alu.sv
`timescale 1ns/1ps

module sc32_alu (
    input  sc32_pkg::alu_op_t i_op,
    input  sc32_pkg::word_t   i_a,
    input  sc32_pkg::word_t   i_b,
    output sc32_pkg::word_t   o_result,
    output logic              o_zero
);
    import sc32_pkg::*;

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb begin
        case (i_op)
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_ADD:  o_result = i_a + i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_SLT:  o_result = word_t'($signed(i_a) < $signed(i_b));
            ALU_SRA:  o_result = word_t'($signed(i_a) >>> shamt);
            ALU_SLTU: o_result = word_t'(i_a < i_b);
            default:  o_result = '0; // unused codes
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// File: sc32_pkg.sv
package sc32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  pc_sel_t;
    typedef logic [1:0]  wb_sel_t;

    // alu operation codes
    localparam alu_op_t ALU_AND  = 4'd0;
    localparam alu_op_t ALU_OR   = 4'd1;
    localparam alu_op_t ALU_ADD  = 4'd2;
    localparam alu_op_t ALU_XOR  = 4'd3;
    localparam alu_op_t ALU_SLL  = 4'd4;
    localparam alu_op_t ALU_SRL  = 4'd5;
    localparam alu_op_t ALU_SUB  = 4'd6;
    localparam alu_op_t ALU_SLT  = 4'd7;
    localparam alu_op_t ALU_SRA  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;

    // next pc source
    localparam pc_sel_t PC_SEQ  = 2'd0; // pc+4, or branch target when taken
    localparam pc_sel_t PC_JAL  = 2'd1;
    localparam pc_sel_t PC_JALR = 2'd2;

    // write-back source
    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_MEM = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    // opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef struct packed {
        logic    reg_write;
        logic    alu_src_imm;       // b operand from immediate
        logic    alu_a_pc;          // a operand from pc (auipc)
        logic    mem_write;
        logic    branch;
        logic    branch_on_nonzero; // take branch when alu result is nonzero
        alu_op_t alu_op;
        pc_sel_t pc_sel;
        wb_sel_t wb_sel;
    } ctrl_t;

endpackage
